/* agu_op_pkg.sv */
`default_nettype none

package agu_op_pkg;

  localparam int op_w         = 64;
  localparam int vaddr_w      = 44;
  localparam int paddr_bank_w = 36;
  localparam int reg_w        = 6;

  // load/store view, slots 0 to 2
  typedef struct packed {
    logic [vaddr_w-1:0] addr_main;
    logic [reg_w-1:0]   reg_no;
    logic [8:0]         lsq;
    logic [4:0]         sz;
  } load_op_t;

  // store-forward view, slot 3
  typedef struct packed {
    logic [paddr_bank_w-1:0] addr_even;
    logic [4:0]              bread;
    logic [1:0]              pbit;
    logic [1:0]              low;
    logic [reg_w-1:0]        reg_no;
    logic [4:0]              sz;
    logic [5:0]              wq;
    logic                    odd;
    logic                    pad;
  } fwd_op_t;

  // same word, read by slot type
  typedef union packed {
    load_op_t ld;
    fwd_op_t  fw;
  } slot_op_u;

endpackage

`default_nettype wire

/* agu_replay_pkg.sv */
`default_nettype none

package agu_replay_pkg;

  // buffer geometry
  localparam int depth = 8;
  localparam int ptr_w = 3;
  localparam int cnt_w = 4;
  localparam int slots = 4;

  // slot whose word holds a store-forward op
  localparam logic [1:0] fwd_slot = 2'd3;

  // register word addresses
  localparam logic [1:0] csr_ctrl   = 2'd0;
  localparam logic [1:0] csr_stall  = 2'd1;
  localparam logic [1:0] csr_status = 2'd2;

  // csr_ctrl bits
  localparam int ctrl_replay_on_bit = 0;
  localparam int ctrl_flush_bit     = 1;

  // csr_status sticky flag
  localparam int status_ovf_bit = 8;

  localparam logic [3:0] stall_level_rst = 4'd4;

endpackage

`default_nettype wire

/* agu_replay_top.sv */
`timescale 1ns/1ps
`default_nettype none

module agu_replay_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 except,
  input  logic                 read_en,
  input  logic                 conflict0,
  input  logic                 conflict1,
  input  logic                 conflict2,
  input  logic                 conflict3,
  input  agu_op_pkg::slot_op_u op0,
  input  agu_op_pkg::slot_op_u op1,
  input  agu_op_pkg::slot_op_u op2,
  input  agu_op_pkg::slot_op_u op3,
  output logic                 rep_en,
  output logic                 rep_fwd,
  output logic [1:0]           rep_slot,
  output agu_op_pkg::slot_op_u rep_op,
  output logic                 skip,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  logic [1:0]           wb_adr,
  input  logic [31:0]          wb_dat_w,
  output logic [31:0]          wb_dat_r,
  output logic                 wb_ack
);

  logic                             replay_on;
  logic [3:0]                       stall_level;
  logic                             flush;
  logic [agu_replay_pkg::cnt_w-1:0] count;
  logic                             overflow_evt;
  logic                             head_valid;
  logic                             issue_ok;
  logic [3:0]                       head_pending;
  logic [1:0]                       pick_slot;
  logic                             pick_done;
  agu_op_pkg::slot_op_u             head_op0;
  agu_op_pkg::slot_op_u             head_op1;
  agu_op_pkg::slot_op_u             head_op2;
  agu_op_pkg::slot_op_u             head_op3;

  replay_csr u_csr (
    .clk(clk), .rst(rst),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .count(count), .overflow_evt(overflow_evt),
    .replay_on(replay_on), .stall_level(stall_level), .flush(flush)
  );

  replay_buffer u_buf (
    .clk(clk), .rst(rst), .except(except), .flush(flush),
    .replay_on(replay_on), .stall_level(stall_level),
    .conflict0(conflict0), .conflict1(conflict1),
    .conflict2(conflict2), .conflict3(conflict3),
    .op0(op0), .op1(op1), .op2(op2), .op3(op3),
    .pick_slot(pick_slot), .pick_done(pick_done), .rep_en(rep_en),
    .head_valid(head_valid), .issue_ok(issue_ok), .head_pending(head_pending),
    .head_op0(head_op0), .head_op1(head_op1),
    .head_op2(head_op2), .head_op3(head_op3),
    .count(count), .overflow_evt(overflow_evt), .skip(skip)
  );

  // issue_ok already carries head_valid
  replay_issue u_issue (
    .read_en(read_en), .issue_ok(issue_ok), .head_pending(head_pending),
    .head_op0(head_op0), .head_op1(head_op1),
    .head_op2(head_op2), .head_op3(head_op3),
    .pick_slot(pick_slot), .pick_done(pick_done),
    .rep_en(rep_en), .rep_slot(rep_slot), .rep_fwd(rep_fwd), .rep_op(rep_op)
  );

endmodule

`default_nettype wire

/* project.f */
+incdir+.
agu_op_pkg.sv
agu_replay_pkg.sv
replay_csr.sv
replay_buffer.sv
replay_issue.sv
agu_replay_top.sv
tb_agu_replay.sv

/* replay_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module replay_buffer (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             except,
  input  logic                             flush,
  input  logic                             replay_on,
  input  logic [3:0]                       stall_level,
  input  logic                             conflict0,
  input  logic                             conflict1,
  input  logic                             conflict2,
  input  logic                             conflict3,
  input  agu_op_pkg::slot_op_u             op0,
  input  agu_op_pkg::slot_op_u             op1,
  input  agu_op_pkg::slot_op_u             op2,
  input  agu_op_pkg::slot_op_u             op3,
  input  logic [1:0]                       pick_slot,
  input  logic                             pick_done,
  input  logic                             rep_en,
  output logic                             head_valid,
  output logic                             issue_ok,
  output logic [3:0]                       head_pending,
  output agu_op_pkg::slot_op_u             head_op0,
  output agu_op_pkg::slot_op_u             head_op1,
  output agu_op_pkg::slot_op_u             head_op2,
  output agu_op_pkg::slot_op_u             head_op3,
  output logic [agu_replay_pkg::cnt_w-1:0] count,
  output logic                             overflow_evt,
  output logic                             skip
);

  logic [agu_replay_pkg::slots-1:0] conflict;
  logic [agu_replay_pkg::slots-1:0] pick_mask;
  logic [agu_replay_pkg::slots-1:0] pending [agu_replay_pkg::depth];
  logic [agu_replay_pkg::depth-1:0] valid;
  logic [agu_replay_pkg::ptr_w-1:0] head;
  logic [agu_replay_pkg::ptr_w-1:0] tail;
  logic                             clear;
  logic                             full;
  logic                             any_confl;
  logic                             wen;
  logic                             retire;

  agu_op_pkg::slot_op_u ops [agu_replay_pkg::depth][agu_replay_pkg::slots];

  assign conflict  = {conflict3, conflict2, conflict1, conflict0};
  assign any_confl = |conflict;
  assign clear     = except | flush;
  assign full      = &valid;

  // full is judged at the start of the cycle, a retire does not make room
  assign wen          = any_confl & ~clear & ~full;
  assign overflow_evt = any_confl & ~clear & full;

  assign pick_mask = {{(agu_replay_pkg::slots-1){1'b0}}, 1'b1} << pick_slot;
  assign retire    = rep_en & pick_done;

  assign head_valid   = valid[head];
  assign issue_ok     = head_valid & replay_on & ~clear;
  assign head_pending = pending[head];
  assign head_op0     = ops[head][0];
  assign head_op1     = ops[head][1];
  assign head_op2     = ops[head][2];
  assign head_op3     = ops[head][3];

  always_ff @(posedge clk) begin
    if (wen) begin
      ops[tail][0] <= op0;
      ops[tail][1] <= op1;
      ops[tail][2] <= op2;
      ops[tail][3] <= op3;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      valid <= '0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < agu_replay_pkg::depth; i++) begin
        pending[i] <= '0;
      end
    end else begin
      // tail and head only meet on a full buffer, where wen is low
      if (wen) begin
        valid[tail]   <= 1'b1;
        pending[tail] <= conflict;
        tail          <= tail + 1'b1;
      end
      if (rep_en) begin
        pending[head] <= head_pending & ~pick_mask;
      end
      if (retire) begin
        valid[head] <= 1'b0;
        head        <= head + 1'b1;
      end
      count <= count + {{(agu_replay_pkg::cnt_w-1){1'b0}}, wen}
                     - {{(agu_replay_pkg::cnt_w-1){1'b0}}, retire};
    end
  end

  // upstream hold with hysteresis between stall_level and empty
  always_ff @(posedge clk) begin
    if (rst) begin
      skip <= 1'b0;
    end else if (count >= stall_level) begin
      skip <= 1'b1;
    end else if (count == '0) begin
      skip <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* replay_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module replay_csr (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             wb_cyc,
  input  logic                             wb_stb,
  input  logic                             wb_we,
  input  logic [1:0]                       wb_adr,
  input  logic [31:0]                      wb_dat_w,
  output logic [31:0]                      wb_dat_r,
  output logic                             wb_ack,
  input  logic [agu_replay_pkg::cnt_w-1:0] count,
  input  logic                             overflow_evt,
  output logic                             replay_on,
  output logic [3:0]                       stall_level,
  output logic                             flush
);

  logic        access;
  logic        wr;
  logic        ovf_clr;
  logic        overflow;
  logic [31:0] rd_word;

  // classic cycle, one access per strobe
  assign access = wb_cyc & wb_stb & ~wb_ack;
  assign wr     = access & wb_we;

  assign ovf_clr = wr && (wb_adr == agu_replay_pkg::csr_status) &&
                   wb_dat_w[agu_replay_pkg::status_ovf_bit];

  // read mux, status built from live count
  always_comb begin
    rd_word = 32'd0;
    case (wb_adr)
      agu_replay_pkg::csr_ctrl: begin
        rd_word[agu_replay_pkg::ctrl_replay_on_bit] = replay_on;
      end
      agu_replay_pkg::csr_stall: begin
        rd_word[3:0] = stall_level;
      end
      agu_replay_pkg::csr_status: begin
        rd_word[agu_replay_pkg::cnt_w-1:0]      = count;
        rd_word[agu_replay_pkg::status_ovf_bit] = overflow;
      end
      default: begin
        rd_word = 32'd0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack      <= 1'b0;
      replay_on   <= 1'b1;
      stall_level <= agu_replay_pkg::stall_level_rst;
      flush       <= 1'b0;
      overflow    <= 1'b0;
    end else begin
      wb_ack <= access;
      // flush bit is a write-1 pulse, never stored
      flush  <= wr && (wb_adr == agu_replay_pkg::csr_ctrl) &&
                wb_dat_w[agu_replay_pkg::ctrl_flush_bit];
      if (wr && (wb_adr == agu_replay_pkg::csr_ctrl)) begin
        replay_on <= wb_dat_w[agu_replay_pkg::ctrl_replay_on_bit];
      end
      if (wr && (wb_adr == agu_replay_pkg::csr_stall)) begin
        stall_level <= wb_dat_w[3:0];
      end
      // a new drop wins over a clear in the same cycle
      overflow <= (overflow & ~ovf_clr) | overflow_evt;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      wb_dat_r <= rd_word;
    end
  end

endmodule

`default_nettype wire

/* replay_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module replay_issue (
  input  logic                 read_en,
  input  logic                 issue_ok,
  input  logic [3:0]           head_pending,
  input  agu_op_pkg::slot_op_u head_op0,
  input  agu_op_pkg::slot_op_u head_op1,
  input  agu_op_pkg::slot_op_u head_op2,
  input  agu_op_pkg::slot_op_u head_op3,
  output logic [1:0]           pick_slot,
  output logic                 pick_done,
  output logic                 rep_en,
  output logic [1:0]           rep_slot,
  output logic                 rep_fwd,
  output agu_op_pkg::slot_op_u rep_op
);

  logic [1:0]                          sel;
  logic                                is_fwd;
  logic [agu_op_pkg::reg_w-1:0]        reg_no;
  logic [agu_op_pkg::vaddr_w-1:0]      addr_main;
  logic [agu_op_pkg::paddr_bank_w-1:0] addr_even;
  agu_op_pkg::slot_op_u                word;
  agu_op_pkg::load_op_t                ld;
  agu_op_pkg::fwd_op_t                 fw;

  // lowest pending slot first
  always_comb begin
    sel = 2'd0;
    for (int i = agu_replay_pkg::slots - 1; i >= 0; i--) begin
      if (head_pending[i]) begin
        sel = 2'(i);
      end
    end
  end

  assign pick_slot = sel;
  assign pick_done = (head_pending & ~(4'b0001 << sel)) == 4'b0000;
  assign rep_en    = issue_ok & read_en;
  assign is_fwd    = sel == agu_replay_pkg::fwd_slot;
  assign rep_slot  = rep_en ? sel : 2'd0;
  assign rep_fwd   = rep_en & is_fwd;

  always_comb begin
    case (sel)
      2'd0:    word = head_op0;
      2'd1:    word = head_op1;
      2'd2:    word = head_op2;
      default: word = head_op3;
    endcase
  end

  assign ld        = word.ld;
  assign fw        = word.fw;
  assign addr_main = ld.addr_main;
  assign addr_even = fw.addr_even;
  // reg_no sits at different bits in the two views
  assign reg_no    = is_fwd ? fw.reg_no : ld.reg_no;

  always_comb begin
    rep_op = {agu_op_pkg::op_w{1'b0}};
    if (rep_en && is_fwd) begin
      rep_op.fw = '{addr_even: addr_even, bread: fw.bread, pbit: fw.pbit,
                    low: fw.low, reg_no: reg_no, sz: fw.sz, wq: fw.wq,
                    odd: fw.odd, pad: 1'b0};
    end else if (rep_en) begin
      rep_op.ld = '{addr_main: addr_main, reg_no: reg_no, lsq: ld.lsq, sz: ld.sz};
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
verilator --binary --timing -f project.f --top-module tb_agu_replay -o sim_tb || exit 1
out=$(./obj_dir/sim_tb 2>&1)
echo "$out"
echo "$out" | grep -q "^NO ERRORS$" && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb_replay_model.svh */
`ifndef TB_REPLAY_MODEL_SVH
`define TB_REPLAY_MODEL_SVH

// stored bundles, oldest first, ops packed slot 0 in the low bits
logic [3:0]   q_pend [$];
logic [255:0] q_ops [$];

// register and output state as it stands after reset
logic         skip_exp      = 1'b0;
logic         ack_exp       = 1'b0;
logic         replay_on_exp = 1'b1;
logic         flush_exp     = 1'b0;
logic         ovf_exp       = 1'b0;
logic [3:0]   stall_exp     = 4'd4;
logic [31:0]  dat_r_exp     = 32'd0;

function automatic logic replay_fires();
  return q_pend.size() != 0 && replay_on_exp && !except && !flush_exp && read_en;
endfunction

function automatic logic [1:0] next_slot();
  logic [3:0] p;
  p = q_pend.size() != 0 ? q_pend[0] : 4'd0;
  return p[0] ? 2'd0 : p[1] ? 2'd1 : p[2] ? 2'd2 : 2'd3;
endfunction

// forward ops come back with the pad bit cleared
function automatic agu_op_pkg::slot_op_u replayed_word();
  logic [255:0]         e;
  agu_op_pkg::slot_op_u w;
  e = replay_fires() ? q_ops[0] : 256'd0;
  w = e[64*int'(next_slot()) +: 64];
  if (next_slot() == agu_replay_pkg::fwd_slot) begin
    w.fw.pad = 1'b0;
  end
  return w;
endfunction

task automatic advance_model();
  logic [3:0] confl;
  logic [3:0] pend;
  logic       acc;
  logic       wr;
  logic       clr;
  logic       full;
  int         cnt;
  confl = {conflict3, conflict2, conflict1, conflict0};
  acc   = wb_cyc && wb_stb && !ack_exp;
  wr    = acc && wb_we;
  clr   = except | flush_exp;
  full  = q_pend.size() == agu_replay_pkg::depth;
  cnt   = q_pend.size();
  // reads see the registers before the edge
  if (acc) begin
    dat_r_exp = wb_adr == agu_replay_pkg::csr_ctrl ? {31'd0, replay_on_exp} :
                wb_adr == agu_replay_pkg::csr_stall ? {28'd0, stall_exp} :
                wb_adr == agu_replay_pkg::csr_status ? {23'd0, ovf_exp, 4'd0, 4'(cnt)} :
                32'd0;
  end
  if (cnt >= int'(stall_exp)) begin
    skip_exp = 1'b1;
  end else if (cnt == 0) begin
    skip_exp = 1'b0;
  end
  if (wr && wb_adr == agu_replay_pkg::csr_status && wb_dat_w[8]) begin
    ovf_exp = 1'b0;
  end
  ovf_exp = ovf_exp | (confl != 4'd0 && !clr && full);
  if (clr) begin
    q_pend.delete();
    q_ops.delete();
  end else begin
    if (replay_fires()) begin
      pend = q_pend[0];
      pend[next_slot()] = 1'b0;
      q_pend[0] = pend;
      if (pend == 4'd0) begin
        void'(q_pend.pop_front());
        void'(q_ops.pop_front());
      end
    end
    // fullness counts from the start of the cycle
    if (confl != 4'd0 && !full) begin
      q_pend.push_back(confl);
      q_ops.push_back({op3, op2, op1, op0});
    end
  end
  ack_exp   = acc;
  flush_exp = wr && wb_adr == agu_replay_pkg::csr_ctrl && wb_dat_w[1];
  if (wr && wb_adr == agu_replay_pkg::csr_ctrl) begin
    replay_on_exp = wb_dat_w[0];
  end
  if (wr && wb_adr == agu_replay_pkg::csr_stall) begin
    stall_exp = wb_dat_w[3:0];
  end
endtask

`endif

/* tb_agu_replay.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_agu_replay;

  logic                 clk;
  logic                 rst;
  logic                 except;
  logic                 read_en;
  logic                 conflict0, conflict1, conflict2, conflict3;
  agu_op_pkg::slot_op_u op0, op1, op2, op3;
  logic                 wb_cyc, wb_stb, wb_we;
  logic [1:0]           wb_adr;
  logic [31:0]          wb_dat_w;
  logic [31:0]          wb_dat_r;
  logic                 wb_ack;
  logic                 rep_en;
  logic                 rep_fwd;
  logic [1:0]           rep_slot;
  agu_op_pkg::slot_op_u rep_op;
  logic                 skip;

  // stimulus mix in percent per cycle
  int          conf_pct;
  int          rd_pct;
  int          exc_pct;
  logic        ack_now;
  logic [31:0] rd_data;

  `include "tb_replay_model.svh"

  agu_replay_top u_dut (.*);

  always #2 clk = ~clk;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped");
  endtask

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] time %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic drive_inputs();
    logic [3:0] c;
    c = 4'd0;
    if ($urandom_range(99) < conf_pct) begin
      c = 4'($urandom_range(15, 1));
    end
    {conflict3, conflict2, conflict1, conflict0} = c;
    op0     = {$urandom, $urandom};
    op1     = {$urandom, $urandom};
    op2     = {$urandom, $urandom};
    op3     = {$urandom, $urandom};
    read_en = $urandom_range(99) < rd_pct;
    except  = $urandom_range(99) < exc_pct;
  endtask

  // check mid-cycle, step the model at the edge and drive at the fall
  task automatic tick();
    #1;
    compare("rep_en", 64'(rep_en), 64'(replay_fires()));
    compare("rep_slot", 64'(rep_slot), replay_fires() ? 64'(next_slot()) : 64'd0);
    compare("rep_fwd", 64'(rep_fwd),
            64'(replay_fires() && next_slot() == agu_replay_pkg::fwd_slot));
    compare("rep_op", rep_op, replayed_word());
    compare("skip", 64'(skip), 64'(skip_exp));
    compare("wb_ack", 64'(wb_ack), 64'(ack_exp));
    if (ack_exp) begin
      compare("wb_dat_r", 64'(wb_dat_r), 64'(dat_r_exp));
    end
    ack_now = wb_ack;
    rd_data = wb_dat_r;
    @(posedge clk);
    advance_model();
    @(negedge clk);
    drive_inputs();
  endtask

  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] data);
    int waited;
    waited   = 0;
    ack_now  = 1'b0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = data;
    while (!ack_now) begin
      if (waited == 16) begin
        stop_run("Wishbone acknowledge never came");
      end else begin
        tick();
        waited++;
      end
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic read_expect(input logic [1:0] adr, input logic [31:0] mask,
                             input logic [31:0] exp, input string name);
    wb_access(1'b0, adr, 32'd0);
    compare(name, 64'(rd_data & mask), 64'(exp));
  endtask

  task automatic drain();
    int waited;
    waited   = 0;
    conf_pct = 0;
    rd_pct   = 100;
    while (q_pend.size() != 0) begin
      if (waited == 64) begin
        stop_run("buffer did not drain with replay enabled");
      end else begin
        tick();
        waited++;
      end
    end
  endtask

  initial begin
    void'($urandom(32'hfbd0));
    clk = 1'b0;
    rst = 1'b1;
    {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w} = '0;
    conf_pct = 0;
    rd_pct   = 0;
    exc_pct  = 0;
    drive_inputs();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    read_expect(agu_replay_pkg::csr_ctrl, 32'hffff_ffff, 32'h1, "csr_ctrl");
    read_expect(agu_replay_pkg::csr_stall, 32'hffff_ffff, 32'h4, "csr_stall");
    read_expect(2'd3, 32'hffff_ffff, 32'h0, "unused address");

    conf_pct = 60;
    rd_pct   = 70;
    exc_pct  = 2;
    repeat (3000) tick();

    // fill a little before one except cycle
    exc_pct  = 0;
    conf_pct = 100;
    rd_pct   = 0;
    repeat (4) tick();
    conf_pct = 0;
    except   = 1'b1;
    read_en  = 1'b1;
    tick();
    read_expect(agu_replay_pkg::csr_status, 32'h0f, 32'h0, "count after except");

    conf_pct = 100;
    repeat (12) tick();
    conf_pct = 0;
    read_expect(agu_replay_pkg::csr_status, 32'h10f, 32'h108, "status when full");
    wb_access(1'b1, agu_replay_pkg::csr_status, 32'h100);
    read_expect(agu_replay_pkg::csr_status, 32'h10f, 32'h008, "status after clear");
    drain();

    repeat (8) begin
      wb_access(1'b1, agu_replay_pkg::csr_stall, $urandom_range(15));
      conf_pct = 100;
      rd_pct   = 0;
      repeat ($urandom_range(10, 1)) tick();
      drain();
    end

    // replay off keeps entries until a flush with replay back on
    wb_access(1'b1, agu_replay_pkg::csr_ctrl, 32'h0);
    conf_pct = 100;
    rd_pct   = 100;
    repeat (6) tick();
    conf_pct = 0;
    wb_access(1'b0, agu_replay_pkg::csr_status, 32'd0);
    compare("count is zero with replay off", 64'(rd_data[3:0] == 4'd0), 64'd0);
    wb_access(1'b1, agu_replay_pkg::csr_ctrl, 32'h3);
    read_expect(agu_replay_pkg::csr_status, 32'h0f, 32'h0, "count after flush");

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire
